/* Makefile */
VERILATOR ?= verilator
TOP       ?= pan_mixer_tb
FILELIST  ?= pan_mixer.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All checks passed

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* pan_mixer.f */
verilog/snd_pkg.sv
verilog/pan_port_decode.sv
verilog/pan_mix_seq.sv
verilog/sigma_delta_dac.sv
verilog/pan_mixer_top.sv
tests/pan_mixer_assert.sv
tests/pan_mixer_tb.sv

/* tests/pan_mixer_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module pan_mixer_assert #(
   parameter logic [7:0] PORT_ADDR = 8'hF7
) (
   input logic       clk,
   input logic       mrst_n,
   input logic [7:0] a,
   input logic       iorq_n,
   input logic       wr_n,
   input logic [7:0] din,
   input logic [7:0] dout,
   input logic       oe_n,
   input logic [3:0] state   // Sequencer frame counter
);

   ////////////////////
   // Sequencer
   ////////////////////

   state_range: assert property (@(posedge clk) disable iff (!mrst_n) state <= 4'd10)
      else $error("sequencer state %0d beyond last state", state);

   state_step: assert property (@(posedge clk) disable iff (!mrst_n)
      (state != 4'd10) |=> (state == $past(state) + 4'd1))
      else $error("sequencer skipped a state");

   state_wrap: assert property (@(posedge clk) disable iff (!mrst_n)
      (state == 4'd10) |=> (state == 4'd0))
      else $error("sequencer did not wrap to state 0");

   ////////////////////
   // Port F7
   ////////////////////

   // A decoded read leaves the register alone
   read_stable: assert property (@(posedge clk) disable iff (!mrst_n)
      (!oe_n && wr_n) |=> $stable(dout))
      else $error("port read disturbed the panning register");

   write_load: assert property (@(posedge clk) disable iff (!mrst_n)
      ((a == PORT_ADDR) && !iorq_n && !wr_n) |=> (dout == $past(din)))
      else $error("port write not visible on dout");

endmodule

bind pan_mixer_top pan_mixer_assert #(.PORT_ADDR(PORT_ADDR)) assert_i (
   .clk(clk), .mrst_n(mrst_n),
   .a(a), .iorq_n(iorq_n), .wr_n(wr_n), .din(din),
   .dout(dout), .oe_n(oe_n),
   .state(seq_i.state)
);

`default_nettype wire

/* tests/pan_mixer_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module pan_mixer_tb;

   import snd_pkg::*;

   localparam int SETTLE    = 22;     // Two full mixing frames
   localparam int WINDOW    = 2048;   // Density window in cycles
   localparam int TOL       = 2;      // Allowed count error per side
   localparam int N_RAND    = 8;
   localparam int NUM_TESTS = 4 + N_RAND + 8;
   localparam int WATCHDOG  = NUM_TESTS * (3 * 11 + 512 * 4) + 500;
   localparam logic [7:0] PORT = 8'hF7;
   localparam pan_cfg_t PAN_INIT = 8'h9F;   // Power-up panning

   logic       clk;
   logic       mrst_n;
   logic [7:0] a;
   logic [7:0] din;
   logic       iorq_n;
   logic       rd_n;
   logic       wr_n;
   logic [7:0] dout;
   logic       oe_n;
   logic       output_left;
   logic       output_right;
   snd_src_t   src_drv;      // All sound inputs
   pan_cfg_t   exp_pan;      // Register model
   integer     seed;
   int         checks;
   int         errors;
   int         test_errs;    // Errors of the running test
   int         tests_done;

   pan_mixer_top dut_i (
      .clk(clk), .mrst_n(mrst_n),
      .a(a), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n), .din(din),
      .dout(dout), .oe_n(oe_n),
      .mic(src_drv.mic), .ear(src_drv.ear), .spk(src_drv.spk),
      .ay1_cha(src_drv.ay1_cha), .ay1_chb(src_drv.ay1_chb), .ay1_chc(src_drv.ay1_chc),
      .ay2_cha(src_drv.ay2_cha), .ay2_chb(src_drv.ay2_chb), .ay2_chc(src_drv.ay2_chc),
      .specdrum(src_drv.specdrum),
      .output_left(output_left), .output_right(output_right)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;   // 20 ns period
   end

   // Watchdog
   initial begin
      repeat (WATCHDOG) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", WATCHDOG);
      $display("Checks failed");
      $finish;
   end

   ////////////////////
   // Model
   ////////////////////

   function automatic logic [7:0] rand_byte();
      logic [31:0] r;
      r = $random(seed);
      return r[7:0];
   endfunction

   function automatic snd_src_t rand_src();
      logic [7:0] bits;
      bits = rand_byte();   // ear, spk, mic from the low three bits
      return {rand_byte(), rand_byte(), rand_byte(), rand_byte(), rand_byte(),
              rand_byte(), rand_byte(), bits[2:0]};
   endfunction

   // Beeper level, index {ear,spk,mic}
   function automatic int beep_model(input logic [2:0] esm);
      int lvl [8] = '{17, 36, 184, 192, 22, 48, 244, 255};
      return lvl[esm];
   endfunction

   function automatic logic [8:0] scale_model(input int sum);
      logic [11:0]        v;
      logic signed [11:0] sv;
      v  = sum[11:0] + 12'hC00;    // Minus eight mid-scale sources
      sv = signed'(v) >>> 2;
      v  = unsigned'(sv) + 12'd256;   // Back to mid scale
      return v[8:0];
   endfunction

   function automatic stereo_sample_t mix_model(input pan_cfg_t p, input snd_src_t s);
      int             pair [4];
      int             sum_l;
      int             sum_r;
      logic [7:0]     pb;
      stereo_sample_t r;
      pb      = p;
      pair[0] = int'(s.ay1_cha) + int'(s.ay2_cha);
      pair[1] = int'(s.ay1_chb) + int'(s.ay2_chb);
      pair[2] = int'(s.ay1_chc) + int'(s.ay2_chc);
      pair[3] = beep_model({s.ear, s.spk, s.mic}) + int'(s.specdrum);
      sum_l   = 0;
      sum_r   = 0;
      for (int i = 0; i < 4; i++) begin
         if (pb[7 - 2 * i]) sum_l += pair[i];   // Left bit of field i
         if (pb[6 - 2 * i]) sum_r += pair[i];
      end
      r.left  = scale_model(sum_l);
      r.right = scale_model(sum_r);
      return r;
   endfunction

   ////////////////////
   // Bus and checks
   ////////////////////

   task automatic idle_bus();
      a      = 8'h00;
      din    = 8'h00;
      iorq_n = 1'b1;
      rd_n   = 1'b1;
      wr_n   = 1'b1;
   endtask

   task automatic port_write(input logic [7:0] addr, input logic [7:0] data, input logic io_n);
      @(negedge clk);
      a      = addr;
      din    = data;
      iorq_n = io_n;
      wr_n   = 1'b0;
      @(negedge clk);   // Write edge passed
      idle_bus();
   endtask

   task automatic port_read(input logic [7:0] addr, output pan_cfg_t data, output logic en_n);
      @(negedge clk);
      a      = addr;
      iorq_n = 1'b0;
      rd_n   = 1'b0;
      #5;               // Mid low phase
      data = dout;
      en_n = oe_n;
      @(negedge clk);
      idle_bus();
   endtask

   task automatic check_pan(input string name, input pan_cfg_t want, input pan_cfg_t act);
      checks++;
      if (act !== want) begin
         errors++;
         test_errs++;
         $display("error %s: expected %02h actual %02h", name, want, act);
      end
   endtask

   task automatic check_bit(input string name, input logic want, input logic act);
      checks++;
      if (act !== want) begin
         errors++;
         test_errs++;
         $display("error %s: expected %b actual %b", name, want, act);
      end
   endtask

   task automatic check_density(input string name, input stereo_sample_t want,
                                input int ones_l, input int ones_r);
      int exp_l;
      int exp_r;
      exp_l  = int'(want.left) * (WINDOW / 512);   // Density is sample / 512
      exp_r  = int'(want.right) * (WINDOW / 512);
      checks += 2;
      if (ones_l > exp_l + TOL || ones_l < exp_l - TOL) begin
         errors++;
         test_errs++;
         $display("error %s left: expected %0d actual %0d", name, exp_l, ones_l);
      end
      if (ones_r > exp_r + TOL || ones_r < exp_r - TOL) begin
         errors++;
         test_errs++;
         $display("error %s right: expected %0d actual %0d", name, exp_r, ones_r);
      end
   endtask

   task automatic end_test(input string name);
      tests_done++;
      $display("test %s done, %0d errors", name, test_errs);
      test_errs = 0;
   endtask

   task automatic count_ones(output int ones_l, output int ones_r);
      ones_l = 0;
      ones_r = 0;
      repeat (WINDOW) begin
         @(negedge clk);
         if (output_left) ones_l++;
         if (output_right) ones_r++;
      end
   endtask

   // Set panning and sources, let two frames pass, then measure
   task automatic density_test(input string name, input pan_cfg_t p, input snd_src_t s);
      int ones_l;
      int ones_r;
      @(negedge clk);
      src_drv = s;
      port_write(PORT, p, 1'b0);
      exp_pan = p;
      repeat (SETTLE) @(negedge clk);
      count_ones(ones_l, ones_r);
      check_density(name, mix_model(exp_pan, s), ones_l, ones_r);
      end_test(name);
   endtask

   ////////////////////
   // Test sequence
   ////////////////////

   initial begin
      pan_cfg_t   rd_val;
      logic       rd_oe;
      logic [7:0] addr;
      logic [7:0] wdata;
      snd_src_t   s;
      seed       = 32'h6adf_e2d1;
      checks     = 0;
      errors     = 0;
      test_errs  = 0;
      tests_done = 0;
      mrst_n     = 1'b0;
      src_drv    = '0;
      exp_pan    = PAN_INIT;
      idle_bus();
      repeat (8) @(negedge clk);
      mrst_n = 1'b1;

      // Reset value and read decode
      port_read(PORT, rd_val, rd_oe);
      check_bit("reset_read oe_n", 1'b0, rd_oe);
      check_pan("reset_read", exp_pan, rd_val);
      addr = rand_byte();
      if (addr == PORT) addr = ~addr;
      port_read(addr, rd_val, rd_oe);
      check_bit("other_read oe_n", 1'b1, rd_oe);
      end_test("reset_read");

      // Write, read back, ignored writes
      repeat (8) begin
         wdata = rand_byte();
         port_write(PORT, wdata, 1'b0);
         exp_pan = wdata;                   // Register takes the written byte
         port_read(PORT, rd_val, rd_oe);
         check_pan("write_read", exp_pan, rd_val);
         addr = rand_byte();
         if (addr == PORT) addr = ~addr;
         port_write(addr, rand_byte(), 1'b0);
         port_write(PORT, rand_byte(), 1'b1);   // IORQ inactive
         port_read(PORT, rd_val, rd_oe);
         check_pan("write_ignore", exp_pan, rd_val);
      end
      end_test("write_read");

      density_test("mute", 8'h00, rand_src());
      for (int i = 0; i < N_RAND; i++)
         density_test($sformatf("rand_pan_%0d", i), rand_byte(), rand_src());
      for (int i = 0; i < 8; i++) begin
         s          = rand_src();
         s.specdrum = 8'h00;
         {s.ear, s.spk, s.mic} = i[2:0];
         density_test($sformatf("beeper_%03b", i[2:0]), 8'h03, s);   // chan_d only
      end

      // Reset in the middle of a run
      port_write(PORT, 8'hFF, 1'b0);
      repeat (SETTLE) @(negedge clk);
      mrst_n = 1'b0;
      @(negedge clk);
      check_bit("reset_out_left", 1'b0, output_left);
      check_bit("reset_out_right", 1'b0, output_right);
      exp_pan = PAN_INIT;
      port_read(PORT, rd_val, rd_oe);   // Decode is live during reset
      check_pan("mid_reset", exp_pan, rd_val);
      repeat (6) @(negedge clk);
      mrst_n = 1'b1;
      port_read(PORT, rd_val, rd_oe);
      check_pan("after_reset", exp_pan, rd_val);
      end_test("mid_reset");

      $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/pan_mix_seq.sv */
`timescale 1ns/1ns
`default_nettype none

module pan_mix_seq (
   input  logic                     clk,
   input  logic                     mrst_n,
   input  snd_pkg::pan_cfg_t        pan,
   input  snd_pkg::snd_src_t        src,
   output snd_pkg::stereo_sample_t  sample
);

   import snd_pkg::*;

   logic [3:0]       state;       // 0..10, one frame per pass
   logic [MIX_W-1:0] mix_left;    // Left accumulator
   logic [MIX_W-1:0] mix_right;   // Right accumulator
   logic [MIX_W-1:0] pair_a;
   logic [MIX_W-1:0] pair_b;
   logic [MIX_W-1:0] pair_c;
   logic [MIX_W-1:0] pair_d;
   logic [7:0]       beeper;

   // Zero-extended sum of two 8-bit sources
   function automatic logic [MIX_W-1:0] pair_sum(input logic [7:0] x, input logic [7:0] y);
      logic [MIX_W-1:0] s;
      s = {{(MIX_W-8){1'b0}}, x} + {{(MIX_W-8){1'b0}}, y};
      return s;
   endfunction

   // Arithmetic shift right by two
   function automatic logic [MIX_W-1:0] asr2(input logic [MIX_W-1:0] v);
      logic [MIX_W-1:0] r;
      r = {{2{v[MIX_W-1]}}, v[MIX_W-1:2]};
      return r;
   endfunction

   ////////////////////
   // Channel pairs
   ////////////////////

   assign beeper = beeper_level({src.ear, src.spk, src.mic});
   assign pair_a = pair_sum(src.ay1_cha, src.ay2_cha);
   assign pair_b = pair_sum(src.ay1_chb, src.ay2_chb);
   assign pair_c = pair_sum(src.ay1_chc, src.ay2_chc);
   assign pair_d = pair_sum(beeper, src.specdrum);   // Beeper shares a field with Specdrum

   ////////////////////
   // Sequencer
   ////////////////////

   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         state     <= 4'd0;
         mix_left  <= '0;
         mix_right <= '0;
         sample    <= '0;   // DACs start from a defined input
      end else begin
         case (state)
            4'd0: begin
               // Previous frame out, new frame starts with channel A
               sample.left  <= mix_left[8:0];
               sample.right <= mix_right[8:0];
               mix_left     <= pan.chan_a[PAN_L] ? pair_a : '0;
            end
            4'd1: mix_right <= pan.chan_a[PAN_R] ? pair_a : '0;
            4'd2: begin
               if (pan.chan_b[PAN_L])
                  mix_left <= mix_left + pair_b;
            end
            4'd3: begin
               if (pan.chan_b[PAN_R])
                  mix_right <= mix_right + pair_b;
            end
            4'd4: begin
               if (pan.chan_c[PAN_L])
                  mix_left <= mix_left + pair_c;
            end
            4'd5: begin
               if (pan.chan_c[PAN_R])
                  mix_right <= mix_right + pair_c;
            end
            4'd6: begin
               if (pan.chan_d[PAN_L])
                  mix_left <= mix_left + pair_d;
            end
            4'd7: begin
               if (pan.chan_d[PAN_R])
                  mix_right <= mix_right + pair_d;
            end
            4'd8: begin
               // Remove the mid-scale bias of eight sources
               mix_left  <= mix_left + MIX_OFFSET;
               mix_right <= mix_right + MIX_OFFSET;
            end
            4'd9: begin
               mix_left  <= asr2(mix_left);    // Signed divide by 4
               mix_right <= asr2(mix_right);
            end
            4'd10: begin
               mix_left  <= mix_left + MIX_REBIAS;
               mix_right <= mix_right + MIX_REBIAS;
            end
            default: begin
               mix_left  <= mix_left;   // Unreachable, counter wraps at 10
               mix_right <= mix_right;
            end
         endcase

         // Frame counter
         state <= (state == SEQ_LAST) ? 4'd0 : state + 4'd1;
      end
   end

endmodule

`default_nettype wire

/* verilog/pan_mixer_top.sv */
`timescale 1ns/1ns
`default_nettype none

module pan_mixer_top #(
   parameter logic [7:0] PORT_ADDR = 8'hF7,
   parameter int         DAC_MSB   = 8
) (
   input  logic       clk,
   input  logic       mrst_n,
   // CPU bus
   input  logic [7:0] a,
   input  logic       iorq_n,
   input  logic       rd_n,
   input  logic       wr_n,
   input  logic [7:0] din,
   output logic [7:0] dout,
   output logic       oe_n,
   // Sound sources
   input  logic       mic,
   input  logic       ear,
   input  logic       spk,
   input  logic [7:0] ay1_cha,
   input  logic [7:0] ay1_chb,
   input  logic [7:0] ay1_chc,
   input  logic [7:0] ay2_cha,
   input  logic [7:0] ay2_chb,
   input  logic [7:0] ay2_chc,
   input  logic [7:0] specdrum,
   // 1-bit audio to the analogue filter
   output logic       output_left,
   output logic       output_right
);

   import snd_pkg::*;

   snd_src_t       src;
   pan_cfg_t       pan;
   stereo_sample_t sample;

   ////////////////////
   // Source bundle
   ////////////////////

   always_comb begin
      src.ay1_cha  = ay1_cha;
      src.ay1_chb  = ay1_chb;
      src.ay1_chc  = ay1_chc;
      src.ay2_cha  = ay2_cha;
      src.ay2_chb  = ay2_chb;
      src.ay2_chc  = ay2_chc;
      src.specdrum = specdrum;
      src.ear      = ear;
      src.spk      = spk;
      src.mic      = mic;
   end

   // Port F7 register
   pan_port_decode #(
      .PORT_ADDR(PORT_ADDR)
   ) decode_i (
      .clk    (clk),
      .mrst_n (mrst_n),
      .a      (a),
      .iorq_n (iorq_n),
      .rd_n   (rd_n),
      .wr_n   (wr_n),
      .din    (din),
      .dout   (dout),
      .oe_n   (oe_n),
      .pan    (pan)
   );

   // 11-clock mixing frame
   pan_mix_seq seq_i (
      .clk    (clk),
      .mrst_n (mrst_n),
      .pan    (pan),
      .src    (src),
      .sample (sample)
   );

   ////////////////////
   // DAC pair
   ////////////////////

   sigma_delta_dac #(
      .DAC_MSB(DAC_MSB)
   ) dac_left_i (
      .clk    (clk),
      .mrst_n (mrst_n),
      .din    (sample.left),
      .out    (output_left)
   );

   sigma_delta_dac #(
      .DAC_MSB(DAC_MSB)
   ) dac_right_i (
      .clk    (clk),
      .mrst_n (mrst_n),
      .din    (sample.right),
      .out    (output_right)
   );

endmodule

`default_nettype wire

/* verilog/pan_port_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module pan_port_decode #(
   parameter logic [7:0] PORT_ADDR = 8'hF7
) (
   input  logic               clk,
   input  logic               mrst_n,
   input  logic [7:0]         a,
   input  logic               iorq_n,
   input  logic               rd_n,
   input  logic               wr_n,
   input  logic [7:0]         din,
   output logic [7:0]         dout,
   output logic               oe_n,
   output snd_pkg::pan_cfg_t  pan
);

   import snd_pkg::*;

   logic     port_hit;   // Address and IORQ match
   logic     wr_hit;
   logic     rd_hit;
   pan_cfg_t pan_r;

   ////////////////////
   // Address decode
   ////////////////////

   assign port_hit = (a == PORT_ADDR) && !iorq_n;
   assign wr_hit   = port_hit && !wr_n;
   assign rd_hit   = port_hit && !rd_n;

   // Panning register, loaded on the write edge
   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         pan_r <= PAN_RESET;
      end else if (wr_hit) begin
         pan_r <= din;   // Visible on dout next cycle
      end
   end

   ////////////////////
   // Read back
   ////////////////////

   // Data always present, enable only while decoded
   always_comb begin
      dout = pan_r;
      oe_n = !rd_hit;
   end

   assign pan = pan_r;   // To the mixing sequencer

endmodule

`default_nettype wire

/* verilog/sigma_delta_dac.sv */
`timescale 1ns/1ns
`default_nettype none

module sigma_delta_dac #(
   parameter int DAC_MSB = 8   // MSB index of din
) (
   input  logic             clk,
   input  logic             mrst_n,
   input  logic [DAC_MSB:0] din,   // Unsigned, full scale 2**(DAC_MSB+1)
   output logic             out
);

   localparam int W = DAC_MSB + 3;   // Two guard bits over the input

   logic [W-1:0] delta_b;     // Fed-back full scale
   logic [W-1:0] delta_sum;   // Delta adder
   logic [W-1:0] sigma_sum;   // Sigma adder
   logic [W-1:0] sigma;       // Integrator

   ////////////////////
   // Delta and sigma adders
   ////////////////////

   // MSB set means integrator above threshold, subtract full scale
   assign delta_b   = {sigma[W-1], sigma[W-1], {(DAC_MSB+1){1'b0}}};
   assign delta_sum = {2'b00, din} + delta_b;
   assign sigma_sum = delta_sum + sigma;

   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         sigma <= {{(W-1){1'b0}}, 1'b1} << (DAC_MSB + 1);   // Mid point
         out   <= 1'b0;
      end else begin
         sigma <= sigma_sum;
         out   <= sigma[W-1];   // One cycle behind the integrator
      end
   end

endmodule

`default_nettype wire

/* verilog/snd_pkg.sv */
`default_nettype none

package snd_pkg;

   ////////////////////
   // Sound source bundle
   ////////////////////

   typedef struct packed {
      logic [7:0] ay1_cha;    // PSG 1 channels
      logic [7:0] ay1_chb;
      logic [7:0] ay1_chc;
      logic [7:0] ay2_cha;    // PSG 2 channels
      logic [7:0] ay2_chb;
      logic [7:0] ay2_chc;
      logic [7:0] specdrum;   // Unsigned sample, 128 is silence
      logic       ear;        // Beeper lines
      logic       spk;
      logic       mic;
   } snd_src_t;

   // Panning register as seen at port F7
   // Each field is {left, right}: 00 mute, 10 left, 01 right, 11 both
   typedef struct packed {
      logic [1:0] chan_a;     // Bits 7:6
      logic [1:0] chan_b;     // Bits 5:4
      logic [1:0] chan_c;     // Bits 3:2
      logic [1:0] chan_d;     // Beeper plus Specdrum
   } pan_cfg_t;

   typedef struct packed {
      logic [8:0] left;
      logic [8:0] right;
   } stereo_sample_t;

   ////////////////////
   // Constants
   ////////////////////

   localparam pan_cfg_t PAN_RESET = 8'h9F;   // ACB stereo, beeper on both sides
   localparam int PAN_L = 1;                 // Bit positions inside a pan field
   localparam int PAN_R = 0;

   localparam int MIX_W = 12;                          // Accumulator width
   localparam logic [MIX_W-1:0] MIX_OFFSET = 12'hC00;  // Minus 8 x 128
   localparam logic [MIX_W-1:0] MIX_REBIAS = 12'd256;  // Back to mid scale
   localparam logic [3:0] SEQ_LAST = 4'd10;            // Last sequencer state

   // Beeper level for {ear,spk,mic}
   function automatic logic [7:0] beeper_level(input logic [2:0] esm);
      logic [7:0] lvl;
      case (esm)
         3'b000:  lvl = 8'd17;
         3'b001:  lvl = 8'd36;
         3'b010:  lvl = 8'd184;
         3'b011:  lvl = 8'd192;
         3'b100:  lvl = 8'd22;
         3'b101:  lvl = 8'd48;
         3'b110:  lvl = 8'd244;
         default: lvl = 8'd255;   // All three high
      endcase
      return lvl;
   endfunction

endpackage

`default_nettype wire
